// File: src/chan_io_block.sv
// channel register block: live link status, loopback control and sticky errors

module chan_io_block
  import chan_io_pkg::*;
(
  input  logic                  io_clk,        // bus clock
  input  logic                  rst_n,         // sync, active low
  io_bus_if.chan_mp             bus,           // this channel's bus slice
  input  chan_status_t          status,        // link status, already on io_clk
  output logic [LOOPBACK_W-1:0] loopback_set   // to the link loopback port
);

  reg_addr_e            reg_off;        // register offset from addr[3:0]
  logic                 wr_hit;         // write strobe for this channel
  logic                 rd_hit;         // read strobe for this channel
  logic [DATA_W-1:0]    live_status_q;  // sampled status, upper bits zero
  logic [DATA_W-1:0]    loopback_q;     // full width loopback register
  logic [STATUS_W-1:0]  err_q;          // sticky error bits
  logic [STATUS_W-1:0]  err_clr;        // write-one-to-clear mask
  logic [STATUS_W-1:0]  err_d;          // next sticky value
  logic [DATA_W-1:0]    rd_data_q;      // readback register
  logic                 rd_ack_q;       // readback valid

  ////////////////////////////////////////////////////////////////////////////
  // request decode

  assign reg_off = reg_addr_e'(bus.addr[3:0]);  // upper offset bits ignored
  assign wr_hit  = bus.sync & bus.sel & bus.wr_en;
  assign rd_hit  = bus.sync & bus.sel & bus.rd_en;

  // live status
  // sampled every cycle, so a read sees the inputs from one edge before
  // the readback register loads
  always_ff @(posedge io_clk) begin
    live_status_q <= DATA_W'(status);  // zero extend to bus width
  end

  // loopback register
  // all 32 bits are kept and read back, only the low ones reach the link
  always_ff @(posedge io_clk) begin
    if (!rst_n) begin
      loopback_q <= '0;
    end else if (wr_hit && (reg_off == REG_LOOPBACK)) begin
      loopback_q <= bus.wr_data;
    end
  end

  assign loopback_set = loopback_q[LOOPBACK_W-1:0];  // 3 lsbs

  ////////////////////////////////////////////////////////////////////////////
  // sticky error register
  // frame, hard and soft errors latch at their status bit positions.
  // A one written to a bit clears it, but an error present in the same
  // cycle sets it again, so a coincident error is never lost.

  assign err_clr = (wr_hit && (reg_off == REG_ERR_LATCH)) ?
                   bus.wr_data[STATUS_W-1:0] : '0;

  assign err_d = (err_q & ~err_clr) | (status & ERR_LATCH_MASK);  // new err wins

  always_ff @(posedge io_clk) begin
    if (!rst_n) begin
      err_q <= '0;
    end else begin
      err_q <= err_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback
  // ack goes high one cycle after the strobe, data loads with it

  always_ff @(posedge io_clk) begin
    if (!rst_n) begin
      rd_ack_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_hit;  // one cycle pulse per read strobe
    end
  end

  always_ff @(posedge io_clk) begin
    if (rd_hit) begin
      case (reg_off)
        REG_LIVE_STATUS: rd_data_q <= live_status_q;
        REG_LOOPBACK:    rd_data_q <= loopback_q;
        REG_ERR_LATCH:   rd_data_q <= DATA_W'(err_q);
        default:         rd_data_q <= '0;  // unmapped offset, still acked
      endcase
    end
  end

  assign bus.rd_data = rd_data_q;
  assign bus.rd_ack  = rd_ack_q;

endmodule

// File: src/chan_io_pkg.sv
// channel I/O package: bus widths, register offsets and link status layout

package chan_io_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus widths
  localparam int DATA_W       = 32;  // host read / write data
  localparam int ADDR_W       = 32;  // full host address
  localparam int CHAN_ADDR_W  = 20;  // left after the 12-bit base field
  localparam int CHAN_SEL_LSB = 16;  // channel number sits in [19:16]

  // link side widths
  localparam int STATUS_W   = 9;  // status bits per channel
  localparam int LOOPBACK_W = 3;  // loopback setting to the link

  ////////////////////////////////////////////////////////////////////////////
  // register offsets inside one channel, taken from addr[3:0]
  // anything not listed here reads back as zero
  typedef enum logic [3:0] {
    REG_LIVE_STATUS = 4'd0,  // sampled link status, read only
    REG_LOOPBACK    = 4'd1,  // read / write, 3 lsbs go to the link
    REG_ERR_LATCH   = 4'd2   // sticky errors, write one to clear
  } reg_addr_e;

  ////////////////////////////////////////////////////////////////////////////
  // link status, channel_up is bit 0 and link_reset is bit 8
  typedef struct packed {
    logic link_reset;      // [8]
    logic rx_resetdone;    // [7]
    logic tx_resetdone;    // [6]
    logic pll_not_locked;  // [5]
    logic soft_err;        // [4]
    logic hard_err;        // [3]
    logic frame_err;       // [2]
    logic lane_up;         // [1]
    logic channel_up;      // [0]
  } chan_status_t;

  // the error bits that get latched in the sticky register
  localparam chan_status_t ERR_LATCH_MASK = '{
    frame_err : 1'b1,
    hard_err  : 1'b1,
    soft_err  : 1'b1,
    default   : 1'b0
  };

endpackage

// File: src/chan_io_top.sv
// channel I/O top: host bus decode, per-channel register blocks and read mux

module chan_io_top
  import chan_io_pkg::*;
#(
  parameter int          NUM_CHAN  = 2,       // 1 to 16 channels
  parameter logic [11:0] BASE_ADDR = 12'h80A  // window in addr[31:20]
) (
  input  logic                           io_clk,
  input  logic                           rst_n,         // sync, active low
  // host bus
  input  logic                           io_sync,       // one cycle strobe
  input  logic [ADDR_W-1:0]              io_addr,
  input  logic                           io_rd_en,
  input  logic                           io_wr_en,
  input  logic [DATA_W-1:0]              io_wr_data,
  output logic [DATA_W-1:0]              io_rd_data,
  output logic                           io_rd_ack,     // two cycles after strobe
  // link side, channel 0 in the low bits
  input  logic [NUM_CHAN*STATUS_W-1:0]   status_in,
  output logic [NUM_CHAN*LOOPBACK_W-1:0] loopback_set
);

  // one bus slice per channel
  io_bus_if chan_bus [NUM_CHAN] ();

  ////////////////////////////////////////////////////////////////////////////
  // decode, combinational

  io_addr_decoder #(
    .NUM_CHAN  (NUM_CHAN),
    .BASE_ADDR (BASE_ADDR)
  ) decoder_i (
    .io_sync    (io_sync),
    .io_addr    (io_addr),
    .io_rd_en   (io_rd_en),
    .io_wr_en   (io_wr_en),
    .io_wr_data (io_wr_data),
    .chan_bus   (chan_bus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // channel blocks, first read stage

  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    chan_io_block chan_i (
      .io_clk       (io_clk),
      .rst_n        (rst_n),
      .bus          (chan_bus[i]),
      .status       (chan_status_t'(status_in[i*STATUS_W +: STATUS_W])),
      .loopback_set (loopback_set[i*LOOPBACK_W +: LOOPBACK_W])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux, second read stage

  io_read_mux #(
    .NUM_CHAN (NUM_CHAN)
  ) read_mux_i (
    .io_clk     (io_clk),
    .rst_n      (rst_n),
    .chan_bus   (chan_bus),
    .io_rd_data (io_rd_data),
    .io_rd_ack  (io_rd_ack)
  );

endmodule

// File: src/io_addr_decoder.sv
// address decoder: checks the base address and selects one channel on the bus

module io_addr_decoder
  import chan_io_pkg::*;
#(
  parameter int          NUM_CHAN  = 2,       // channels behind this decoder
  parameter logic [11:0] BASE_ADDR = 12'h80A  // required in addr[31:20]
) (
  input  logic              io_sync,     // strobe from the host
  input  logic [ADDR_W-1:0] io_addr,     // full host address
  input  logic              io_rd_en,    // read
  input  logic              io_wr_en,    // write
  input  logic [DATA_W-1:0] io_wr_data,  // write data
  io_bus_if.decoder_mp      chan_bus [NUM_CHAN]
);

  localparam int SEL_W = 4;  // width of the channel number field

  logic             base_hit;  // top 12 bits match our window
  logic [SEL_W-1:0] chan_num;  // channel field of the address

  ////////////////////////////////////////////////////////////////////////////
  // common decode

  assign base_hit = (io_addr[ADDR_W-1:CHAN_ADDR_W] == BASE_ADDR);
  assign chan_num = io_addr[CHAN_SEL_LSB +: SEL_W];

  ////////////////////////////////////////////////////////////////////////////
  // fan out to the channels
  // only indices below NUM_CHAN exist, so a larger channel number selects
  // nothing and a read to it is never acknowledged

  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    // select only the one matching channel
    assign chan_bus[i].sel     = base_hit & (chan_num == SEL_W'(i));
    // the rest is broadcast, sel qualifies it in the channel
    assign chan_bus[i].sync    = io_sync;
    assign chan_bus[i].addr    = io_addr[CHAN_ADDR_W-1:0];  // low 20 bits
    assign chan_bus[i].rd_en   = io_rd_en;
    assign chan_bus[i].wr_en   = io_wr_en;
    assign chan_bus[i].wr_data = io_wr_data;
  end

endmodule

// File: src/io_bus_if.sv
// per-channel slice of the host I/O bus between decoder, channel and read mux

interface io_bus_if
  import chan_io_pkg::*;
();

  // request side, from the decoder
  logic                   sel;      // this channel is addressed
  logic                   sync;     // one cycle strobe starting the operation
  logic [CHAN_ADDR_W-1:0] addr;     // low address bits, base already checked
  logic                   rd_en;    // read operation
  logic                   wr_en;    // write operation
  logic [DATA_W-1:0]      wr_data;  // write payload

  // answer side, from the channel block
  logic [DATA_W-1:0]      rd_data;  // registered readback
  logic                   rd_ack;   // one cycle, rd_data valid

  // decoder drives the request
  modport decoder_mp (
    output sel, sync, addr, rd_en, wr_en, wr_data
  );

  // channel takes the request and answers reads
  modport chan_mp (
    input  sel, sync, addr, rd_en, wr_en, wr_data,
    output rd_data, rd_ack
  );

  // read mux only looks at the answers
  modport mux_mp (
    input rd_data, rd_ack
  );

endinterface

// File: src/io_read_mux.sv
// read mux: merges the channel answers into one registered read data and ack

module io_read_mux
  import chan_io_pkg::*;
#(
  parameter int NUM_CHAN = 2  // channels feeding the mux
) (
  input  logic              io_clk,      // bus clock
  input  logic              rst_n,       // sync, active low
  io_bus_if.mux_mp          chan_bus [NUM_CHAN],
  output logic [DATA_W-1:0] io_rd_data,  // to the host
  output logic              io_rd_ack    // to the host
);

  logic [NUM_CHAN-1:0] ack_vec;                 // per channel ack
  logic [DATA_W-1:0]   data_gated [NUM_CHAN];   // data of acking channels only
  logic [DATA_W-1:0]   data_or;                 // merged data
  logic                rd_data_ld;              // any channel answering
  logic [DATA_W-1:0]   rd_data_q;
  logic                rd_ack_q;

  ////////////////////////////////////////////////////////////////////////////
  // pull the answers out of the interfaces

  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    assign ack_vec[i]    = chan_bus[i].rd_ack;
    assign data_gated[i] = chan_bus[i].rd_ack ? chan_bus[i].rd_data : '0;
  end

  // only one channel acks per cycle, so a plain OR is the mux
  always_comb begin
    data_or = '0;
    for (int i = 0; i < NUM_CHAN; i++) begin
      data_or = data_or | data_gated[i];
    end
  end

  assign rd_data_ld = |ack_vec;

  ////////////////////////////////////////////////////////////////////////////
  // output stage

  always_ff @(posedge io_clk) begin
    if (!rst_n) begin
      rd_ack_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_data_ld;
    end
  end

  always_ff @(posedge io_clk) begin
    if (rd_data_ld) begin
      rd_data_q <= data_or;  // holds between reads
    end
  end

  assign io_rd_data = rd_data_q;
  assign io_rd_ack  = rd_ack_q;

endmodule

// File: testbench/chan_io_assert.sv
// bound checks on the host read handshake and the reset state of the read path

module chan_io_assert (
  input logic io_clk,
  input logic rst_n,
  input logic io_sync,
  input logic io_rd_en,
  input logic io_wr_en,
  input logic io_rd_ack
);

  int unsigned fail_cnt = 0;  // failed properties so far

  ////////////////////////////////////////////////////////////////////////////
  // reset state of the read answer

  // a reset edge leaves the ack low for the following cycle too
  ack_low_in_reset : assert property (@(posedge io_clk) !rst_n |=> !io_rd_ack)
    else begin
      $error("read ack high during or right after reset");
      fail_cnt++;
    end

  ////////////////////////////////////////////////////////////////////////////
  // handshake

  // two register stages between strobe and ack
  ack_follows_read : assert property (@(posedge io_clk) disable iff (!rst_n)
    io_rd_ack |-> $past(io_sync && io_rd_en, 2))
    else begin
      $error("read ack without a read strobe two cycles before");
      fail_cnt++;
    end

  one_enable_per_strobe : assert property (@(posedge io_clk) disable iff (!rst_n)
    io_sync |-> !(io_rd_en && io_wr_en))
    else begin
      $error("read and write enable high on the same strobe");
      fail_cnt++;
    end

endmodule

bind chan_io_top chan_io_assert assert_i (
  .io_clk    (io_clk),
  .rst_n     (rst_n),
  .io_sync   (io_sync),
  .io_rd_en  (io_rd_en),
  .io_wr_en  (io_wr_en),
  .io_rd_ack (io_rd_ack)
);

// File: testbench/chan_io_tb.sv
// testbench for the channel I/O subsystem with random register traffic against a cycle model

module chan_io_tb
  import chan_io_pkg::*;
();

  localparam int          NUM_CHAN   = 2;
  localparam logic [11:0] BASE_ADDR  = 12'h80A;
  localparam int          CLK_PERIOD = 4;
  localparam int          RST_CYCLES = 8;
  localparam int          NUM_OPS    = 120;           // bound on strobes issued
  localparam logic [STATUS_W-1:0] ERR_BITS = 9'h01C;  // frame, hard, soft at [4:2]

  logic                           io_clk;
  logic                           rst_n;
  logic                           io_sync;
  logic [ADDR_W-1:0]              io_addr;
  logic                           io_rd_en;
  logic                           io_wr_en;
  logic [DATA_W-1:0]              io_wr_data;
  logic [DATA_W-1:0]              io_rd_data;
  logic                           io_rd_ack;
  logic [NUM_CHAN*STATUS_W-1:0]   status_in;
  logic [NUM_CHAN*LOOPBACK_W-1:0] loopback_set;

  // model state as the DUT registers hold it after the last edge
  logic [DATA_W-1:0]   m_loop [NUM_CHAN] = '{default: '0};
  logic [STATUS_W-1:0] m_err  [NUM_CHAN] = '{default: '0};
  logic [STATUS_W-1:0] m_live [NUM_CHAN] = '{default: '0};

  // expected read answers with the oldest first
  int unsigned       exp_due  [$];  // negedge count where the ack is due
  logic [DATA_W-1:0] exp_data [$];
  string             exp_name [$];

  int unsigned neg_cnt = 0;  // negedges seen so far
  string       test_name = "startup";

  chan_io_top #(
    .NUM_CHAN  (NUM_CHAN),
    .BASE_ADDR (BASE_ADDR)
  ) dut_i (
    .io_clk       (io_clk),
    .rst_n        (rst_n),
    .io_sync      (io_sync),
    .io_addr      (io_addr),
    .io_rd_en     (io_rd_en),
    .io_wr_en     (io_wr_en),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_ack    (io_rd_ack),
    .status_in    (status_in),
    .loopback_set (loopback_set)
  );

  initial begin
    io_clk = 1'b0;
    forever #(CLK_PERIOD/2) io_clk = ~io_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reporting and checks

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host side drivers that all start at a rising edge

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge io_clk);
      io_sync  <= 1'b0;
      io_rd_en <= 1'b0;
      io_wr_en <= 1'b0;
    end
  endtask

  task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge io_clk);
    io_sync    <= 1'b1;
    io_addr    <= addr;
    io_rd_en   <= 1'b0;
    io_wr_en   <= 1'b1;
    io_wr_data <= data;
  endtask

  task automatic host_read(input logic [ADDR_W-1:0] addr);
    @(posedge io_clk);
    io_sync    <= 1'b1;
    io_addr    <= addr;
    io_rd_en   <= 1'b1;
    io_wr_en   <= 1'b0;
    io_wr_data <= $urandom();  // junk that reads must ignore
  endtask

  // no wait here so the status changes with the strobe driven at the same edge
  task automatic drive_status(input int ch, input logic [STATUS_W-1:0] st);
    status_in[ch*STATUS_W +: STATUS_W] <= st;
  endtask

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [11:0] base,
                                                 input logic [3:0] ch, input logic [3:0] off);
    return {base, ch, 12'h000, off};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic bit chan_hit(input logic [ADDR_W-1:0] addr);
    return (addr[31:20] == BASE_ADDR) && (int'(addr[19:16]) < NUM_CHAN);
  endfunction

  function automatic logic [DATA_W-1:0] model_read(input int ch, input logic [3:0] off);
    case (off)
      4'd0:    return DATA_W'(m_live[ch]);  // nine bits with zero above
      4'd1:    return m_loop[ch];
      4'd2:    return DATA_W'(m_err[ch]);
      default: return '0;                   // unmapped offsets still ack
    endcase
  endfunction

  // check the stable outputs at the negedge and then step the model over the next edge
  always @(negedge io_clk) begin : model_and_monitor
    int                             ch;
    logic [3:0]                     off;
    logic [STATUS_W-1:0]            clr;
    logic [NUM_CHAN*LOOPBACK_W-1:0] lb_exp;
    ch  = int'(io_addr[19:16]);
    off = io_addr[3:0];
    if (rst_n) begin
      if ((exp_due.size() != 0) && (exp_due[0] == neg_cnt)) begin
        if (io_rd_ack !== 1'b1) begin
          abort_run($sformatf("missing read ack in test %s", exp_name[0]));
        end else begin
          check_value(exp_name[0], exp_data[0], io_rd_data);
          void'(exp_due.pop_front());
          void'(exp_data.pop_front());
          void'(exp_name.pop_front());
        end
      end else if (io_rd_ack !== 1'b0) begin
        abort_run($sformatf("unexpected read ack in test %s", test_name));
      end
      for (int c = 0; c < NUM_CHAN; c++) begin
        lb_exp[c*LOOPBACK_W +: LOOPBACK_W] = m_loop[c][LOOPBACK_W-1:0];
      end
      check_value({test_name, " loopback_set"}, DATA_W'(lb_exp), DATA_W'(loopback_set));
      // read seen now answers two negedges later
      if (io_sync && io_rd_en && chan_hit(io_addr)) begin
        exp_due.push_back(neg_cnt + 2);
        exp_data.push_back(model_read(ch, off));
        exp_name.push_back(test_name);
      end
    end
    for (int c = 0; c < NUM_CHAN; c++) begin
      if (!rst_n) begin
        m_loop[c] = '0;
        m_err[c]  = '0;
      end else begin
        clr = '0;
        if (io_sync && io_wr_en && chan_hit(io_addr) && (ch == c)) begin
          if (off == 4'd1) m_loop[c] = io_wr_data;
          if (off == 4'd2) clr = io_wr_data[STATUS_W-1:0];  // write one to clear
        end
        // a live error beats the clear
        m_err[c] = (m_err[c] & ~clr) | (status_in[c*STATUS_W +: STATUS_W] & ERR_BITS);
      end
      m_live[c] = status_in[c*STATUS_W +: STATUS_W];  // sampled even in reset
    end
    neg_cnt++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin : stimulus
    int                  ch;
    logic [STATUS_W-1:0] st;
    logic [11:0]         bad_base;
    void'($urandom(3814));
    rst_n      <= 1'b0;
    io_sync    <= 1'b0;
    io_addr    <= '0;
    io_rd_en   <= 1'b0;
    io_wr_en   <= 1'b0;
    io_wr_data <= '0;
    status_in  <= '0;
    repeat (RST_CYCLES) @(posedge io_clk);
    rst_n <= 1'b1;

    test_name = "reset_state";
    drive_idle(2);
    for (int c = 0; c < NUM_CHAN; c++) begin
      host_read(reg_addr(BASE_ADDR, 4'(c), REG_LOOPBACK));
      host_read(reg_addr(BASE_ADDR, 4'(c), REG_ERR_LATCH));
    end
    drive_idle(4);

    test_name = "loopback_write";
    repeat (8) begin
      ch = $urandom_range(NUM_CHAN-1, 0);
      host_write(reg_addr(BASE_ADDR, 4'(ch), REG_LOOPBACK), $urandom());
      host_read(reg_addr(BASE_ADDR, 4'(ch), REG_LOOPBACK));
    end
    drive_idle(3);

    test_name = "live_status";
    repeat (4) begin
      for (int c = 0; c < NUM_CHAN; c++) drive_status(c, STATUS_W'($urandom()));
      drive_idle(3);  // status held before the read samples it
      for (int c = 0; c < NUM_CHAN; c++) host_read(reg_addr(BASE_ADDR, 4'(c), REG_LIVE_STATUS));
      drive_idle(2);
    end

    test_name = "sticky_error";
    for (int c = 0; c < NUM_CHAN; c++) drive_status(c, '0);
    drive_idle(2);
    repeat (6) begin
      ch = $urandom_range(NUM_CHAN-1, 0);
      st = ERR_BITS & STATUS_W'($urandom());
      if (st == '0) st = 9'h004;
      drive_status(ch, st);  // one cycle error pulse
      drive_idle(1);
      drive_status(ch, '0);
      drive_idle(2);
      host_read(reg_addr(BASE_ADDR, 4'(ch), REG_ERR_LATCH));
      host_write(reg_addr(BASE_ADDR, 4'(ch), REG_ERR_LATCH), $urandom());
      drive_status(ch, ERR_BITS & STATUS_W'($urandom()));  // may hit the clear cycle
      drive_idle(1);
      drive_status(ch, '0);
      drive_idle(2);
      host_read(reg_addr(BASE_ADDR, 4'(ch), REG_ERR_LATCH));
      drive_idle(2);
    end

    test_name = "address_decode";
    repeat (6) begin
      bad_base = 12'($urandom());
      if (bad_base == BASE_ADDR) bad_base = bad_base ^ 12'h001;
      ch = $urandom_range(NUM_CHAN-1, 0);
      host_write(reg_addr(bad_base, 4'(ch), REG_LOOPBACK), $urandom());
      host_read(reg_addr(bad_base, 4'(ch), REG_LOOPBACK));
      ch = $urandom_range(15, NUM_CHAN);  // channel that does not exist
      host_write(reg_addr(BASE_ADDR, 4'(ch), REG_LOOPBACK), $urandom());
      host_read(reg_addr(BASE_ADDR, 4'(ch), REG_LOOPBACK));
    end
    drive_idle(3);
    for (int c = 0; c < NUM_CHAN; c++) host_read(reg_addr(BASE_ADDR, 4'(c), REG_LOOPBACK));
    repeat (6) begin
      ch = $urandom_range(NUM_CHAN-1, 0);
      host_read(reg_addr(BASE_ADDR, 4'(ch), 4'($urandom_range(15, 3))));
    end
    drive_idle(4);

    test_name = "pipelined_reads";
    for (int c = 0; c < NUM_CHAN; c++) drive_status(c, STATUS_W'($urandom()));
    drive_idle(3);
    repeat (16) begin
      ch = $urandom_range(NUM_CHAN-1, 0);
      host_read(reg_addr(BASE_ADDR, 4'(ch), 4'($urandom_range(2, 0))));
    end
    drive_idle(1);

    while (exp_due.size() != 0) @(negedge io_clk);
    drive_idle(4);  // room for a stray ack to show up
    if (dut_i.assert_i.fail_cnt == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("bound assertions failed during the run");
    end
  end

  // run length bound from the operation count
  initial begin : watchdog
    #((RST_CYCLES + NUM_OPS * 10 + 100) * CLK_PERIOD);
    abort_run("timeout, the run did not finish in the expected time");
  end

endmodule

// File: vlog.f
src/chan_io_pkg.sv
src/io_bus_if.sv
src/io_addr_decoder.sv
src/chan_io_block.sv
src/io_read_mux.sv
src/chan_io_top.sv
testbench/chan_io_assert.sv
testbench/chan_io_tb.sv
